// File: source/formula_pkg.sv
/*
 * Shared register map, pipeline depth and bus/datapath structs for the
 * formula accelerator. Referenced by scoped name from RTL and testbench.
 */

package formula_pkg;

    // ----------------------------------------------------------
    // Pipeline depth
    // ----------------------------------------------------------

    // One stage per root bit of a 32-bit radicand
    localparam int ISQRT_STAGES = 16;

    // ----------------------------------------------------------
    // Register map (word indices)
    // ----------------------------------------------------------

    localparam logic [2:0] ADDR_A    = 3'd0;
    localparam logic [2:0] ADDR_B    = 3'd1;
    localparam logic [2:0] ADDR_C    = 3'd2;
    localparam logic [2:0] ADDR_CTRL = 3'd3;
    localparam logic [2:0] ADDR_RES  = 3'd4;

    // Control word on write, status word on read
    localparam int CTRL_START_BIT = 0;
    localparam int STAT_BUSY_BIT  = 0;
    localparam int STAT_DONE_BIT  = 1;

    // ----------------------------------------------------------
    // Structs
    // ----------------------------------------------------------

    // Wishbone classic request from the master
    typedef struct packed
    {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [2:0]  adr;
        logic [31:0] dat;
    } wb_req_t;

    // Wishbone classic response from the slave
    typedef struct packed
    {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    typedef struct packed
    {
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
    } formula_args_t;

    typedef struct packed
    {
        logic        vld;
        logic [31:0] x;
    } isqrt_req_t;

    typedef struct packed
    {
        logic        vld;
        logic [15:0] y;
    } isqrt_rsp_t;

endpackage

// File: source/isqrt_pipe.sv
/*
 * Fully pipelined floor square root of a 32-bit value, one root bit per stage.
 * Accepts a request every cycle; the root appears ISQRT_STAGES cycles later.
 */

`timescale 1ns/1ps

module isqrt_pipe
(
    input  logic                    clk,
    input  logic                    rst,
    input  formula_pkg::isqrt_req_t req,
    output formula_pkg::isqrt_rsp_t rsp
);

    localparam int STAGES = formula_pkg::ISQRT_STAGES;

    // Per-stage payload, rem holds x minus root squared
    typedef struct packed
    {
        logic [31:0] rem;
        logic [15:0] root;
    } stage_t;

    stage_t stage_in [STAGES];
    stage_t stage_q  [STAGES];
    logic   vld_in   [STAGES];
    logic   vld_q    [STAGES];

    genvar s;

    // ----------------------------------------------------------
    // Stage inputs
    // ----------------------------------------------------------

    // First stage starts with the full radicand and an empty root
    assign stage_in[0] = '{rem: req.x, root: '0};
    assign vld_in[0]   = req.vld;

    for (s = 1; s < STAGES; s++)
    begin : g_link
        assign stage_in[s] = stage_q[s - 1];
        assign vld_in[s]   = vld_q[s - 1];
    end

    // ----------------------------------------------------------
    // Stages
    // ----------------------------------------------------------

    for (s = 0; s < STAGES; s++)
    begin : g_stage
        // Root bit decided here, MSB first
        localparam int BIT = STAGES - 1 - s;

        logic [31:0] trial;
        stage_t      stage_d;

        // Setting bit BIT grows root^2 by 2^(BIT+1)*root + 2^(2*BIT)
        // Lower root bits are still zero, so the sum stays below 2^32
        always_comb
        begin
            trial   = (32'(stage_in[s].root) << (BIT + 1)) + (32'd1 << (2 * BIT));
            stage_d = stage_in[s];
            if (stage_in[s].rem >= trial)
            begin
                stage_d.rem       = stage_in[s].rem - trial;
                stage_d.root[BIT] = 1'b1;
            end
        end

        // Valid bit travels with the item
        always_ff @(posedge clk)
        begin
            if (rst)
                vld_q[s] <= 1'b0;
            else
                vld_q[s] <= vld_in[s];
        end

        always_ff @(posedge clk)
        begin
            stage_q[s] <= stage_d;
        end
    end

    // Last stage holds the finished root
    assign rsp = '{vld: vld_q[STAGES - 1], y: stage_q[STAGES - 1].root};

endmodule

// File: source/formula_2_ctrl.sv
/*
 * Sequencer for res = isqrt(a + isqrt(b + isqrt(c))) over one isqrt unit.
 * Issues c, then b + root, then a + root, and pulses done with the last root.
 */

`timescale 1ns/1ps

module formula_2_ctrl
(
    input  logic                       clk,
    input  logic                       rst,
    input  formula_pkg::formula_args_t args,
    input  logic                       start,
    output formula_pkg::isqrt_req_t    isqrt_req,
    input  formula_pkg::isqrt_rsp_t    isqrt_rsp,
    output logic                       done_pulse,
    output logic [15:0]                result
);

    // ----------------------------------------------------------
    // States
    // ----------------------------------------------------------

    typedef enum logic [1:0]
    {
        st_idle         = 2'd0,
        st_wait_c_res   = 2'd1,
        st_wait_bc_res  = 2'd2,
        st_wait_abc_res = 2'd3
    } state_t;

    state_t state;
    state_t next_state;

    // Root zero-extended for the 32-bit wrapping sums
    logic [31:0] root_ext;
    logic        last_root;

    assign root_ext  = 32'(isqrt_rsp.y);
    assign last_root = (state == st_wait_abc_res) && isqrt_rsp.vld;

    // ----------------------------------------------------------
    // Next state and isqrt request
    // ----------------------------------------------------------

    always_comb
    begin
        next_state = state;
        isqrt_req  = '0;

        case (state)
            st_idle:
            begin
                // c goes out in the same cycle as start
                if (start)
                begin
                    isqrt_req.vld = 1'b1;
                    isqrt_req.x   = args.c;
                    next_state    = st_wait_c_res;
                end
            end

            st_wait_c_res:
            begin
                if (isqrt_rsp.vld)
                begin
                    isqrt_req.vld = 1'b1;
                    isqrt_req.x   = args.b + root_ext;
                    next_state    = st_wait_bc_res;
                end
            end

            st_wait_bc_res:
            begin
                if (isqrt_rsp.vld)
                begin
                    isqrt_req.vld = 1'b1;
                    isqrt_req.x   = args.a + root_ext;
                    next_state    = st_wait_abc_res;
                end
            end

            st_wait_abc_res:
            begin
                if (isqrt_rsp.vld)
                    next_state = st_idle;
            end

            default:
            begin
                next_state = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            state <= st_idle;
        else
            state <= next_state;
    end

    // ----------------------------------------------------------
    // Result capture
    // ----------------------------------------------------------

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            done_pulse <= 1'b0;
            result     <= '0;
        end
        else
        begin
            done_pulse <= last_root;
            // Result stays until the next job finishes
            if (last_root)
                result <= isqrt_rsp.y;
        end
    end

endmodule

// File: source/wb_formula_regs.sv
/*
 * Wishbone classic slave for the formula accelerator: operand registers,
 * start control, busy/done status and result readback.
 */

`timescale 1ns/1ps

module wb_formula_regs
(
    input  logic                       clk,
    input  logic                       rst,
    input  formula_pkg::wb_req_t       bus_req,
    output formula_pkg::wb_rsp_t       bus_rsp,
    output formula_pkg::formula_args_t args,
    output logic                       start,
    input  logic                       done_pulse,
    input  logic [15:0]                result
);

    logic        ack_q;
    logic [31:0] rd_data_q;
    logic [31:0] rd_data;
    logic        busy_q;
    logic        done_q;
    logic        req_hit;
    logic        wr_hit;
    logic        rd_hit;
    logic        start_req;

    // ----------------------------------------------------------
    // Bus decode
    // ----------------------------------------------------------

    // No hit during ack, so a held request is served once
    assign req_hit   = bus_req.cyc && bus_req.stb && !ack_q;
    assign wr_hit    = req_hit && bus_req.we;
    assign rd_hit    = req_hit && !bus_req.we;
    assign start_req = wr_hit && (bus_req.adr == formula_pkg::ADDR_CTRL)
                       && bus_req.dat[formula_pkg::CTRL_START_BIT];

    always_ff @(posedge clk)
    begin
        if (rst)
            ack_q <= 1'b0;
        else
            ack_q <= req_hit;
    end

    // Operand writes land at the request edge
    always_ff @(posedge clk)
    begin
        if (wr_hit)
        begin
            case (bus_req.adr)
                formula_pkg::ADDR_A: args.a <= bus_req.dat;
                formula_pkg::ADDR_B: args.b <= bus_req.dat;
                formula_pkg::ADDR_C: args.c <= bus_req.dat;
                default: ;
            endcase
        end
    end

    // ----------------------------------------------------------
    // Start pulse and status
    // ----------------------------------------------------------

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            start  <= 1'b0;
            busy_q <= 1'b0;
            done_q <= 1'b0;
        end
        else
        begin
            // Pulse lines up with ack, ignored while a job runs
            start <= start_req && !busy_q;
            if (start)
            begin
                busy_q <= 1'b1;
                done_q <= 1'b0;
            end
            else if (done_pulse)
            begin
                busy_q <= 1'b0;
                done_q <= 1'b1;
            end
        end
    end

    // ----------------------------------------------------------
    // Read path
    // ----------------------------------------------------------

    always_comb
    begin
        rd_data = '0;
        case (bus_req.adr)
            formula_pkg::ADDR_A:   rd_data = args.a;
            formula_pkg::ADDR_B:   rd_data = args.b;
            formula_pkg::ADDR_C:   rd_data = args.c;
            formula_pkg::ADDR_CTRL:
            begin
                rd_data[formula_pkg::STAT_BUSY_BIT] = busy_q;
                rd_data[formula_pkg::STAT_DONE_BIT] = done_q;
            end
            formula_pkg::ADDR_RES: rd_data = 32'(result);
            default: ;
        endcase
    end

    // Read data presented together with ack
    always_ff @(posedge clk)
    begin
        if (rd_hit)
            rd_data_q <= rd_data;
    end

    assign bus_rsp = '{ack: ack_q, dat: rd_data_q};

endmodule

// File: source/formula_2_top.sv
/*
 * Top level of the formula accelerator: Wishbone register block,
 * control FSM and the shared isqrt pipeline.
 */

`timescale 1ns/1ps

module formula_2_top
(
    input  logic                 clk,
    input  logic                 rst,
    input  formula_pkg::wb_req_t bus_req,
    output formula_pkg::wb_rsp_t bus_rsp
);

    formula_pkg::formula_args_t args;
    logic                       start;
    logic                       done_pulse;
    logic [15:0]                result;
    formula_pkg::isqrt_req_t    isqrt_req;
    formula_pkg::isqrt_rsp_t    isqrt_rsp;

    // ----------------------------------------------------------
    // Host side
    // ----------------------------------------------------------

    wb_formula_regs wb_formula_regs_inst
    (
        .clk        (clk),
        .rst        (rst),
        .bus_req    (bus_req),
        .bus_rsp    (bus_rsp),
        .args       (args),
        .start      (start),
        .done_pulse (done_pulse),
        .result     (result)
    );

    // ----------------------------------------------------------
    // Sequencer and root unit
    // ----------------------------------------------------------

    formula_2_ctrl formula_2_ctrl_inst
    (
        .clk        (clk),
        .rst        (rst),
        .args       (args),
        .start      (start),
        .isqrt_req  (isqrt_req),
        .isqrt_rsp  (isqrt_rsp),
        .done_pulse (done_pulse),
        .result     (result)
    );

    isqrt_pipe isqrt_pipe_inst
    (
        .clk (clk),
        .rst (rst),
        .req (isqrt_req),
        .rsp (isqrt_rsp)
    );

endmodule

// File: verif/formula_2_tb.sv
/*
 * Self-checking testbench for the formula accelerator. Drives the Wishbone
 * port, checks results against a floor square root model, ends on a watchdog.
 */

`timescale 1ns/1ps

module formula_2_tb;

    localparam int STAGES         = formula_pkg::ISQRT_STAGES;
    localparam int JOB_CYCLES     = 3 * STAGES + 40;
    // Directed, square, random and busy-start jobs together
    localparam int NUM_RANDOM     = 40;
    localparam int NUM_JOBS       = 7 + NUM_RANDOM;
    localparam int TIMEOUT_CYCLES = NUM_JOBS * JOB_CYCLES + 500;
    localparam int POLL_LIMIT     = 3 * STAGES + 40;

    localparam logic [31:0] CTRL_START = 32'd1 << formula_pkg::CTRL_START_BIT;
    localparam logic [31:0] STAT_BUSY  = 32'd1 << formula_pkg::STAT_BUSY_BIT;
    localparam logic [31:0] STAT_DONE  = 32'd1 << formula_pkg::STAT_DONE_BIT;

    logic                 clk = 1'b0;
    logic                 rst;
    formula_pkg::wb_req_t bus_req;
    formula_pkg::wb_rsp_t bus_rsp;

    int          errors;
    int          checks;
    integer      seed;
    int          i;
    logic [31:0] rd_val;
    logic [31:0] ra;
    logic [31:0] rb;
    logic [31:0] rc;

    // Flat copies for the protocol properties
    logic ack;
    logic req_seen;

    assign ack      = bus_rsp.ack;
    assign req_seen = bus_req.cyc && bus_req.stb;

    always #5 clk = ~clk;

    formula_2_top formula_2_top_inst
    (
        .clk     (clk),
        .rst     (rst),
        .bus_req (bus_req),
        .bus_rsp (bus_rsp)
    );

    // ----------------------------------------------------------
    // Bus protocol properties
    // ----------------------------------------------------------

    ack_single: assert property (@(posedge clk) disable iff (rst) ack |-> !$past(ack))
    else
    begin
        errors++;
        $display("** Error at %0t: ack stayed high for two cycles in a row", $time);
    end

    ack_after_req: assert property (@(posedge clk) disable iff (rst) ack |-> $past(req_seen))
    else
    begin
        errors++;
        $display("** Error at %0t: ack raised without a request in the cycle before", $time);
    end

    // ----------------------------------------------------------
    // Reference model
    // ----------------------------------------------------------

    // Largest r with r*r <= x, by binary search
    function automatic logic [15:0] floor_sqrt(input logic [31:0] x);
        logic [31:0] lo;
        logic [31:0] hi;
        logic [31:0] mid;
        lo = 32'd0;
        hi = 32'd65535;
        while (lo < hi)
        begin
            mid = (lo + hi + 32'd1) >> 1;
            if (64'(mid) * 64'(mid) <= 64'(x))
                lo = mid;
            else
                hi = mid - 32'd1;
        end
        return lo[15:0];
    endfunction

    // Sums wrap modulo 2^32
    function automatic logic [15:0] formula_ref(input logic [31:0] a, b, c);
        logic [15:0] y;
        logic [31:0] sum;
        y   = floor_sqrt(c);
        sum = b + 32'(y);
        y   = floor_sqrt(sum);
        sum = a + 32'(y);
        return floor_sqrt(sum);
    endfunction

    // ----------------------------------------------------------
    // Checks and bus tasks
    // ----------------------------------------------------------

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
        checks++;
        assert (got === exp)
        else
        begin
            errors++;
            $display("** Error at %0t: %s expected 0x%08h, got 0x%08h", $time, name, exp, got);
        end
    endtask

    // Called 1 ns after an edge, returns 1 ns after an edge
    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic wb_write(input logic [2:0] adr, input logic [31:0] dat);
        logic got;
        got          = 1'b0;
        bus_req.cyc  = 1'b1;
        bus_req.stb  = 1'b1;
        bus_req.we   = 1'b1;
        bus_req.adr  = adr;
        bus_req.dat  = dat;
        while (!got)
        begin
            @(posedge clk);
            #1;
            got = bus_rsp.ack;
        end
        bus_req = '0;
    endtask

    task automatic wb_read(input logic [2:0] adr, output logic [31:0] dat);
        logic got;
        got          = 1'b0;
        bus_req.cyc  = 1'b1;
        bus_req.stb  = 1'b1;
        bus_req.we   = 1'b0;
        bus_req.adr  = adr;
        bus_req.dat  = '0;
        while (!got)
        begin
            @(posedge clk);
            #1;
            got = bus_rsp.ack;
        end
        // Data is valid while ack is high
        dat     = bus_rsp.dat;
        bus_req = '0;
    endtask

    // ----------------------------------------------------------
    // Job tasks
    // ----------------------------------------------------------

    task automatic load_args(input logic [31:0] a, b, c);
        wb_write(formula_pkg::ADDR_A, a);
        wb_write(formula_pkg::ADDR_B, b);
        wb_write(formula_pkg::ADDR_C, c);
    endtask

    // Accepted start sets busy and clears done
    task automatic start_job();
        logic [31:0] st;
        wb_write(formula_pkg::ADDR_CTRL, CTRL_START);
        wb_read(formula_pkg::ADDR_CTRL, st);
        check_value("status after start", STAT_BUSY, st);
    endtask

    task automatic wait_done();
        logic [31:0] st;
        int          polls;
        st    = '0;
        polls = 0;
        while (!(st & STAT_DONE) && polls < POLL_LIMIT)
        begin
            wb_read(formula_pkg::ADDR_CTRL, st);
            polls++;
        end
        assert (st & STAT_DONE)
        else
        begin
            errors++;
            $display("** Error at %0t: done not set after %0d status polls", $time, polls);
        end
        // Busy must be gone once done shows
        check_value("status at done", STAT_DONE, st);
    endtask

    task automatic check_result(input logic [31:0] a, b, c);
        logic [31:0] res;
        wb_read(formula_pkg::ADDR_RES, res);
        check_value("result", 32'(formula_ref(a, b, c)), res);
    endtask

    task automatic run_job(input logic [31:0] a, b, c);
        load_args(a, b, c);
        start_job();
        wait_done();
        check_result(a, b, c);
    endtask

    // ----------------------------------------------------------
    // Watchdog
    // ----------------------------------------------------------

    initial
    begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles, a job or bus cycle never finished", TIMEOUT_CYCLES);
        $display("Regression failed");
        $finish;
    end

    // ----------------------------------------------------------
    // Stimulus
    // ----------------------------------------------------------

    initial
    begin
        errors  = 0;
        checks  = 0;
        seed    = 32'hf7d1;
        rst     = 1'b1;
        bus_req = '0;
        idle_cycles(8);
        rst = 1'b0;

        // Reset state
        check_value("bus_rsp.ack", 32'd0, 32'(bus_rsp.ack));
        wb_read(formula_pkg::ADDR_CTRL, rd_val);
        check_value("status after reset", 32'd0, rd_val);
        wb_read(formula_pkg::ADDR_RES, rd_val);
        check_value("result after reset", 32'd0, rd_val);

        // Register readback, result register is read only
        load_args(32'h1234_5678, 32'h9abc_def0, 32'h0f1e_2d3c);
        wb_write(formula_pkg::ADDR_RES, 32'hdead_beef);
        wb_read(formula_pkg::ADDR_A, rd_val);
        check_value("reg A", 32'h1234_5678, rd_val);
        wb_read(formula_pkg::ADDR_B, rd_val);
        check_value("reg B", 32'h9abc_def0, rd_val);
        wb_read(formula_pkg::ADDR_C, rd_val);
        check_value("reg C", 32'h0f1e_2d3c, rd_val);
        wb_read(formula_pkg::ADDR_RES, rd_val);
        check_value("result after write", 32'd0, rd_val);
        for (i = 5; i < 8; i++)
        begin
            wb_read(3'(i), rd_val);
            check_value("unmapped read", 32'd0, rd_val);
        end

        // Directed cases
        run_job(32'd0, 32'd0, 32'd0);
        run_job(32'd0, 32'd5, 32'd16);
        run_job(32'hffff_ffff, 32'hffff_ffff, 32'hffff_ffff);
        // Every sum along the chain a perfect square
        run_job(32'd31, 32'd16, 32'd81);
        run_job(32'd65280, 32'd1, 32'hfffe_0001);

        // Random operand sets
        for (i = 0; i < NUM_RANDOM; i++)
        begin
            ra = $random(seed);
            rb = $random(seed);
            rc = $random(seed);
            run_job(ra, rb, rc);
        end

        // Second start during a job is dropped
        load_args(32'd1000, 32'd2000, 32'd3000);
        start_job();
        wb_write(formula_pkg::ADDR_CTRL, CTRL_START);
        wait_done();
        check_result(32'd1000, 32'd2000, 32'd3000);
        idle_cycles(3 * STAGES + 10);
        wb_read(formula_pkg::ADDR_CTRL, rd_val);
        check_value("status with no second job", STAT_DONE, rd_val);
        // Next accepted start clears done
        run_job(32'h0000_ffff, 32'h7fff_0000, 32'h0001_0000);

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
        begin
            $display("Regression passed");
        end
        else
        begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: tb.f
source/formula_pkg.sv
source/isqrt_pipe.sv
source/formula_2_ctrl.sv
source/wb_formula_regs.sv
source/formula_2_top.sv
verif/formula_2_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the formula accelerator testbench with Verilator.
# Exit status is 0 only when the simulation log holds the pass message.

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
BUILD_LOG=build.log
SIM_LOG=sim.log
SIM_BIN=formula_2_sim

rm -rf "$BUILD_DIR" "$BUILD_LOG" "$SIM_LOG"

if ! verilator --binary --timing --assert \
        --top-module formula_2_tb \
        -f tb.f \
        --Mdir "$BUILD_DIR" -o "$SIM_BIN" > "$BUILD_LOG" 2>&1; then
    echo "Build failed, see $BUILD_LOG"
    exit 1
fi

if ! "./$BUILD_DIR/$SIM_BIN" > "$SIM_LOG" 2>&1; then
    echo "Simulation exited with an error, see $SIM_LOG"
    exit 1
fi

if grep -qx "Regression passed" "$SIM_LOG"; then
    echo "PASS"
    exit 0
else
    echo "FAIL, see $SIM_LOG"
    exit 1
fi
